// File: Makefile
# Verilator build and run of the maze display testbench.
TOP := maze_display_tb

.PHONY: all lint clean

# Build, run, and pass only when the pass line shows up.
all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

// File: list.f
source/maze_pkg.sv
source/vga_timing.sv
source/draw_map.sv
source/draw_player.sv
source/pixel_mux.sv
source/maze_display.sv
tests/maze_display_assert.sv
tests/maze_display_tb.sv

// File: source/draw_map.sv
// Wall layer for STAGE1 only. The result lags the scan position by one clock.
`timescale 1ns/1ps

module draw_map (
    input  logic                  clk,
    input  logic                  rst_n,
    input  maze_pkg::game_state_e state,
    input  maze_pkg::scan_t       scan,
    output maze_pkg::render_t     wall
);
    import maze_pkg::*;

    logic [8:0]            x;
    logic [8:0]            y;
    logic [8:0]            mx;
    logic [8:0]            my;
    logic [5:0]            col;
    logic [5:0]            row;
    logic [MAZE_CELLS-1:0] row_bits;
    logic                  in_field;
    logic                  wall_bit;
    logic [2:0]            tx;
    logic [2:0]            ty;
    render_t               wall_next;

    // Half-resolution position.
    assign x = scan.h_cnt[9:1];
    assign y = scan.v_cnt[9:1];

    always_comb begin
        // Offset into the 200x200 field.
        mx       = x - 9'(MAZE_X0);
        my       = y - 9'(MAZE_Y0);
        in_field = (x >= 9'(MAZE_X0)) && (x < 9'(MAZE_X0 + MAZE_CELLS * TILE)) &&
                   (y >= 9'(MAZE_Y0)) && (y < 9'(MAZE_Y0 + MAZE_CELLS * TILE));
        col      = 6'(mx / TILE);
        row      = 6'(my / TILE);
        // Bitmap lookup only inside the field.
        row_bits = '0;
        wall_bit = 1'b0;
        if (in_field) begin
            row_bits = WALL_MAP[(MAZE_CELLS - 1 - row) * MAZE_CELLS +: MAZE_CELLS];
            wall_bit = row_bits[MAZE_CELLS - 1 - col];
        end
        // Position inside the 5x5 tile.
        tx = 3'(x % TILE);
        ty = 3'(y % TILE);
        wall_next.hit        = (state == STAGE1) && scan.active && wall_bit;
        wall_next.pixel_addr = '0;
        if (wall_next.hit) begin
            wall_next.pixel_addr = 17'((tx + (ty + WALL_TEX_ROW) * TEX_WIDTH) % TEX_WORDS);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wall <= '0;
        end else begin
            wall <= wall_next;
        end
    end

endmodule

// File: source/draw_player.sv
// Player sprite for the three stage states. Window may run past the screen edge. One clock latency.
`timescale 1ns/1ps

module draw_player (
    input  logic                  clk,
    input  logic                  rst_n,
    input  maze_pkg::game_state_e state,
    input  maze_pkg::scan_t       scan,
    input  logic [8:0]            player_x,
    input  logic [8:0]            player_y,
    output maze_pkg::render_t     sprite
);
    import maze_pkg::*;

    logic [8:0] x;
    logic [8:0] y;
    logic [8:0] dx;
    logic [8:0] dy;
    logic       in_x;
    logic       in_y;
    logic       stage_on;
    render_t    sprite_next;

    // Half-resolution position.
    assign x = scan.h_cnt[9:1];
    assign y = scan.v_cnt[9:1];

    always_comb begin
        // Distance from the sprite corner.
        dx       = x - player_x;
        dy       = y - player_y;
        // Compare by difference so player_x+19 never wraps.
        in_x     = (x >= player_x) && (dx < 9'(SPRITE_SIZE));
        in_y     = (y >= player_y) && (dy < 9'(SPRITE_SIZE));
        stage_on = state inside {STAGE1, STAGE2, STAGE3};
        sprite_next.hit        = stage_on && scan.active && in_x && in_y;
        sprite_next.pixel_addr = '0;
        // Sprite occupies texture rows 200 to 219.
        if (sprite_next.hit) begin
            sprite_next.pixel_addr = 17'(dx + (dy + SPRITE_TEX_ROW) * TEX_WIDTH);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sprite <= '0;
        end else begin
            sprite <= sprite_next;
        end
    end

endmodule

// File: source/maze_display.sv
// Display path top. State and player position are sampled with the scan and show up two clocks later.
`timescale 1ns/1ps

module maze_display (
    input  logic                  clk,
    input  logic                  rst_n,
    input  maze_pkg::game_state_e state,
    input  logic [8:0]            player_x,
    input  logic [8:0]            player_y,
    output maze_pkg::pixel_t      pixel
);
    import maze_pkg::*;

    // Shared scan position.
    scan_t   scan;
    // Renderer results, one clock behind the scan.
    render_t wall;
    render_t sprite;

    // Raster generator.
    vga_timing u_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .scan  (scan)
    );

    // Wall layer.
    draw_map u_map (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .scan  (scan),
        .wall  (wall)
    );

    // Player layer.
    draw_player u_player (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .scan     (scan),
        .player_x (player_x),
        .player_y (player_y),
        .sprite   (sprite)
    );

    // Merge and align syncs.
    pixel_mux u_mux (
        .clk    (clk),
        .rst_n  (rst_n),
        .scan   (scan),
        .wall   (wall),
        .sprite (sprite),
        .pixel  (pixel)
    );

endmodule

// File: source/maze_pkg.sv
// Shared constants and types for a 640x480 raster at one pixel per clock. WALL_MAP holds row 0 in its top 40 bits.
package maze_pkg;

    // Horizontal raster in pixels.
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // Vertical raster in lines.
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Maze field on the 320x240 half-resolution screen.
    localparam int MAZE_X0    = 60;
    localparam int MAZE_Y0    = 30;
    localparam int TILE       = 5;
    localparam int MAZE_CELLS = 40;

    // Texture picture layout.
    localparam int WALL_TEX_ROW   = 120;
    localparam int SPRITE_SIZE    = 20;
    localparam int SPRITE_TEX_ROW = 200;
    localparam int TEX_WIDTH      = 320;
    localparam int TEX_WORDS      = 76800;

    // Stage-one maze, 1 is wall.
    // Row r sits at bits [(39-r)*40 +: 40], column 0 is the row MSB.
    localparam logic [MAZE_CELLS*MAZE_CELLS-1:0] WALL_MAP = {
        40'b1111111111_1111111111_1111111111_1111111111,
        40'b1000000000_0000000001_0000000000_0000000001,
        40'b1000000000_0000000001_0000000000_0000000001,
        40'b1000000000_0000000001_0000000000_0000000001,
        40'b1000000000_0000000001_0000000000_0000000001,
        40'b1000011111_1111100001_1111111111_1111100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_1111111111_1111111110_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_0000000000_0000000000_0000100001,
        40'b1000010000_1111111111_1111111111_1111100001,
        40'b1000010000_0000000000_0000000000_0000000001,
        40'b1000010000_0000000000_0000000000_0000000001,
        40'b0000010000_0000000000_0000000000_0000000000,
        40'b0000010000_0000000000_0000000000_0000000000,
        40'b0000010000_1111111111_1111111111_1111100000,
        40'b0000010000_1000000000_0000000000_0000100000,
        40'b1000010000_1000000000_0000000000_0000100001,
        40'b1000010000_1000000000_0000000000_0000100001,
        40'b1000010000_1000000000_0000000000_0000100001,
        40'b1000010000_1000010000_1100001000_0000100001,
        40'b1000010000_1000010000_1100001000_0000000001,
        40'b1000010000_1000010000_1100001000_0000000001,
        40'b1000010000_1000010000_1100001000_0000000001,
        40'b1000000000_0000010000_1100001000_0000000001,
        40'b1000000000_0000010000_1100001000_0111100001,
        40'b1000000000_0000010000_1100001000_0111100001,
        40'b1000000000_0000010000_1100001000_0111100001,
        40'b1111111111_1111111111_1100001000_0111100001,
        40'b1111111111_1111111111_1100001000_0111100001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1000000000_0000000000_0000001000_0000000001,
        40'b1111111111_1111111111_1111111111_1111111111
    };

    // Game states driven by the game logic.
    typedef enum logic [3:0] {
        TITLE    = 4'd0,
        STAFF    = 4'd1,
        STAGE1   = 4'd2,
        SUCCESS1 = 4'd3,
        STAGE2   = 4'd4,
        SUCCESS2 = 4'd5,
        STAGE3   = 4'd6,
        SUCCESS3 = 4'd7,
        FAIL     = 4'd8
    } game_state_e;

    // Layer that supplied a pixel.
    typedef enum logic [1:0] {
        BACKGROUND = 2'd0,
        WALL       = 2'd1,
        PLAYER     = 2'd2
    } layer_e;

    // Scan position with raw, undelayed syncs.
    typedef struct packed {
        logic [9:0] h_cnt;
        logic [9:0] v_cnt;
        logic       active;
        logic       hsync;
        logic       vsync;
    } scan_t;

    // One renderer result.
    typedef struct packed {
        logic        hit;
        logic [16:0] pixel_addr;
    } render_t;

    // Final pixel with aligned syncs.
    typedef struct packed {
        logic        valid;
        layer_e      layer;
        logic [16:0] pixel_addr;
        logic        hsync;
        logic        vsync;
    } pixel_t;

endpackage

// File: source/pixel_mux.sv
// Player over wall over background. Output lags the scan by two clocks with syncs delayed to match.
`timescale 1ns/1ps

module pixel_mux (
    input  logic              clk,
    input  logic              rst_n,
    input  maze_pkg::scan_t   scan,
    input  maze_pkg::render_t wall,
    input  maze_pkg::render_t sprite,
    output maze_pkg::pixel_t  pixel
);
    import maze_pkg::*;

    logic   active_d;
    logic   hsync_d;
    logic   vsync_d;
    pixel_t pixel_next;

    // First stage lines up with the renderer registers.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end else begin
            active_d <= scan.active;
            hsync_d  <= scan.hsync;
            vsync_d  <= scan.vsync;
        end
    end

    // Priority select.
    // Renderers already drop hits in blanking.
    always_comb begin
        pixel_next.valid = active_d;
        pixel_next.hsync = hsync_d;
        pixel_next.vsync = vsync_d;
        if (sprite.hit) begin
            pixel_next.layer      = PLAYER;
            pixel_next.pixel_addr = sprite.pixel_addr;
        end else if (wall.hit) begin
            pixel_next.layer      = WALL;
            pixel_next.pixel_addr = wall.pixel_addr;
        end else begin
            pixel_next.layer      = BACKGROUND;
            pixel_next.pixel_addr = '0;
        end
    end

    // Second stage, syncs idle high out of reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel <= '{
                valid:      1'b0,
                layer:      BACKGROUND,
                pixel_addr: 17'd0,
                hsync:      1'b1,
                vsync:      1'b1
            };
        end else begin
            pixel <= pixel_next;
        end
    end

endmodule

// File: source/vga_timing.sv
// Free-running raster from reset with syncs active low. The scan output is combinational from the counters.
`timescale 1ns/1ps

module vga_timing (
    input  logic            clk,
    input  logic            rst_n,
    output maze_pkg::scan_t scan
);
    import maze_pkg::*;

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_last;
    logic       v_last;

    // Last pixel of a line.
    assign h_last = (h_cnt == 10'(H_TOTAL - 1));
    // Last line of a frame.
    assign v_last = (v_cnt == 10'(V_TOTAL - 1));

    // Pixel counter, one step per clock.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // Line counter moves at the end of each line.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_cnt <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    // Decode visible area and sync pulses.
    always_comb begin
        scan.h_cnt  = h_cnt;
        scan.v_cnt  = v_cnt;
        scan.active = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));
        // Low from 656 to 751.
        scan.hsync  = !((h_cnt >= 10'(H_ACTIVE + H_FRONT)) &&
                        (h_cnt < 10'(H_ACTIVE + H_FRONT + H_SYNC)));
        // Low on lines 490 and 491.
        scan.vsync  = !((v_cnt >= 10'(V_ACTIVE + V_FRONT)) &&
                        (v_cnt < 10'(V_ACTIVE + V_FRONT + V_SYNC)));
    end

endmodule

// File: tests/maze_display_assert.sv
// Checks on the combined pixel, bound into the mux. Syncs idle high, so no pulse is cut by reset.
`timescale 1ns/1ps

module maze_display_assert (
    input logic             clk,
    input logic             rst_n,
    input maze_pkg::pixel_t pixel
);
    import maze_pkg::*;

    // Failures so far, watched by the testbench.
    int unsigned fails = 0;
    // Length of the current hsync pulse.
    logic [9:0] hs_low;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_low <= '0;
        end else if (!pixel.hsync) begin
            hs_low <= hs_low + 10'd1;
        end else begin
            hs_low <= '0;
        end
    end

    // Pulse that just ended was 96 pixels.
    hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pixel.hsync) |-> (hs_low == 10'(H_SYNC)))
    else begin
        fails++;
        $error("hsync pulse lasted %0d pixels", hs_low);
    end

    // Blanked pixels carry no texture.
    blank_is_background: assert property (@(posedge clk) disable iff (!rst_n)
        !pixel.valid |-> (pixel.layer == BACKGROUND && pixel.pixel_addr == 17'd0))
    else begin
        fails++;
        $error("blanked pixel with layer %0d address %0d", pixel.layer, pixel.pixel_addr);
    end

    // Drawn layers only in the visible area.
    layer_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (pixel.layer == PLAYER || pixel.layer == WALL) |-> pixel.valid)
    else begin
        fails++;
        $error("layer %0d outside the visible area", pixel.layer);
    end

endmodule

// File: tests/maze_display_tb.sv
// Four frames against a pixel model, stopping at the first mismatch. Needs timing support in the simulator.
`timescale 1ns/1ps

module maze_display_tb;
    import maze_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RUN_FRAMES   = 4;
    localparam int RUN_CYCLES   = RUN_FRAMES * FRAME_CYCLES;
    // One spare frame before the run counts as hung.
    localparam int CYCLE_LIMIT  = (RUN_FRAMES + 1) * FRAME_CYCLES;

    // Scan position and inputs seen at one rising edge.
    typedef struct packed {
        logic        used;
        logic [9:0]  h;
        logic [9:0]  v;
        game_state_e state;
        logic [8:0]  px;
        logic [8:0]  py;
    } sample_t;

    logic          clk;
    logic          rst_n;
    game_state_e   state;
    logic [8:0]    player_x;
    logic [8:0]    player_y;
    pixel_t        pixel;
    logic [31:0]   rng;
    // Entry 1 is the sample from two edges back.
    sample_t [1:0] hist = '0;
    logic [9:0]    tb_h = '0;
    logic [9:0]    tb_v = '0;
    int            cycles = 0;
    int            wall_pixels = 0;
    int            player_pixels = 0;

    maze_display DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .state    (state),
        .player_x (player_x),
        .player_y (player_y),
        .pixel    (pixel)
    );

    bind pixel_mux maze_display_assert u_assert (
        .clk   (clk),
        .rst_n (rst_n),
        .pixel (pixel)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // Expected output for one sampled scan position.
    function automatic pixel_t expected_pixel(input sample_t s);
        pixel_t      p;
        int          h;
        int          v;
        int          x;
        int          y;
        logic        act;
        logic        wall_hit;
        logic        player_hit;
        logic [10:0] bit_idx;
        p = '{valid: 1'b0, layer: BACKGROUND, pixel_addr: 17'd0, hsync: 1'b1, vsync: 1'b1};
        // Nothing sampled yet, so still the reset value.
        if (!s.used) begin
            return p;
        end
        h = int'(s.h);
        v = int'(s.v);
        x = h / 2;
        y = v / 2;
        act = (h < 640) && (v < 480);
        p.valid = act;
        // Pulses on pixels 656..751 and lines 490..491.
        p.hsync = !(h >= 656 && h <= 751);
        p.vsync = !(v == 490 || v == 491);
        wall_hit = 1'b0;
        if (s.state == STAGE1 && act && x >= 60 && x <= 259 && y >= 30 && y <= 229) begin
            // Row 0 on top and column 0 at the row MSB.
            bit_idx  = 11'(1599 - ((y - 30) / 5) * 40 - (x - 60) / 5);
            wall_hit = WALL_MAP[bit_idx];
        end
        player_hit = (s.state inside {STAGE1, STAGE2, STAGE3}) && act &&
                     x >= int'(s.px) && x <= int'(s.px) + 19 &&
                     y >= int'(s.py) && y <= int'(s.py) + 19;
        if (player_hit) begin
            p.layer      = PLAYER;
            p.pixel_addr = 17'(x - int'(s.px) + (y - int'(s.py) + 200) * 320);
        end else if (wall_hit) begin
            p.layer      = WALL;
            p.pixel_addr = 17'((x % 5 + (y % 5 + 120) * 320) % 76800);
        end
        return p;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("** Error at %0d ns: %s got %0d expected %0d", $time, what, got, want);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on the pixel output");
        end
    endtask

    // Inputs for the sample taken at the next rising edge.
    task automatic drive_inputs(input int cyc);
        int frame;
        int line;
        int pix;
        int nx;
        int ny;
        frame = cyc / FRAME_CYCLES;
        line  = (cyc % FRAME_CYCLES) / H_TOTAL;
        pix   = cyc % H_TOTAL;
        case (frame)
            0: begin
                // Full maze with the sprite outside the field.
                state    = STAGE1;
                player_x = 9'd0;
                player_y = 9'd0;
            end
            1: begin
                // Sprite sits in the maze field within each state's band of lines.
                player_x = 9'd150;
                if (line < 175) begin
                    state    = TITLE;
                    player_y = 9'd60;
                end else if (line < 350) begin
                    state    = FAIL;
                    player_y = 9'd120;
                end else begin
                    state    = STAGE2;
                    player_y = 9'd180;
                end
            end
            2: begin
                state = STAGE1;
                // New spot in the blanking of every 40th line.
                if (pix == 700 && line % 40 == 0) begin
                    rng      = xorshift(rng);
                    player_x = 9'(40 + rng % 240);
                    player_y = 9'(20 + (rng >> 16) % 220);
                end
            end
            default: begin
                rng = xorshift(rng);
                // Mid-line changes with the sprite near the beam.
                if (rng[5:0] == 6'd0) begin
                    state    = game_state_e'(4'((rng >> 8) % 9));
                    nx       = pix / 2 - int'(rng[19:16]);
                    ny       = line / 2 - int'(rng[23:20]);
                    player_x = 9'((nx < 0) ? 0 : nx);
                    player_y = 9'((ny < 0) ? 0 : ny);
                end
            end
        endcase
    endtask

    // Output before the edge belongs to the sample from two edges back.
    always @(posedge clk) begin : compare
        pixel_t want;
        string  where;
        if (rst_n) begin
            want  = expected_pixel(hist[1]);
            where = $sformatf(" at h=%0d v=%0d", hist[1].h, hist[1].v);
            check_value(32'(pixel.valid), 32'(want.valid), {"valid", where});
            check_value(32'(pixel.layer), 32'(want.layer), {"layer", where});
            check_value(32'(pixel.pixel_addr), 32'(want.pixel_addr), {"address", where});
            check_value(32'(pixel.hsync), 32'(want.hsync), {"hsync", where});
            check_value(32'(pixel.vsync), 32'(want.vsync), {"vsync", where});
            if (pixel.layer == WALL) begin
                wall_pixels++;
            end
            if (pixel.layer == PLAYER) begin
                player_pixels++;
            end
            hist[1] = hist[0];
            hist[0] = '{used: 1'b1, h: tb_h, v: tb_v, state: state,
                        px: player_x, py: player_y};
            // Local 800 by 525 raster.
            if (tb_h == 10'd799) begin
                tb_h = 10'd0;
                tb_v = (tb_v == 10'd524) ? 10'd0 : tb_v + 10'd1;
            end else begin
                tb_h = tb_h + 10'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // Watch the failure count of the bound checks.
    always @(negedge clk) begin
        if (DUT.u_mux.u_assert.fails != 0) begin
            $display("An assertion on the pixel output failed");
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        rst_n    = 1'b0;
        state    = TITLE;
        player_x = 9'd0;
        player_y = 9'd0;
        rng      = 32'hfef0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            if (cyc != 0) begin
                @(negedge clk);
            end
            drive_inputs(cyc);
        end
        // Drain the two pipeline stages.
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value(32'(wall_pixels != 0), 32'd1, "wall pixels drawn");
        check_value(32'(player_pixels != 0), 32'd1, "player pixels drawn");
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
